// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= cache_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
verilog/cache_pkg.sv
verilog/cache_store.sv
verilog/cache_ctrl.sv
verilog/line_memory.sv
verilog/cache_top.sv
verif/cache_tb.sv

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int MEM_LINES      = 16;
    localparam int MEM_LATENCY    = 4;
    localparam int MEM_WORDS      = MEM_LINES * 4;
    localparam int IDX_W          = $clog2(MEM_WORDS);
    localparam int NUM_TESTS      = 22;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (MEM_LATENCY + 10) * 2;

    localparam logic RD   = 1'b0;
    localparam logic WR   = 1'b1;
    localparam logic HIT  = 1'b1;
    localparam logic MISS = 1'b0;

    // One table row with access kind, word address, write data and expected verdict
    typedef struct packed {
        logic        is_write;
        cache_addr_t addr;
        word_t       wdata;
        logic        exp_hit;
    } test_entry_t;

    logic     clk;
    logic     reset_n;
    cpu_req_t i_req;
    logic     o_ready;
    word_t    o_rdata;
    logic     o_rd_done;

    test_entry_t tests [NUM_TESTS];
    // Expected memory contents, word addressed
    word_t       ref_mem [MEM_WORDS];
    integer      seed;
    int          cycle_count;
    int          error_count;
    int          pass_count;

    cache_top #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) cache_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_req     (i_req),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata),
        .o_rd_done (o_rd_done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the cache did not finish the tests within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic test_entry_t make_entry(input logic is_write, input logic [15:0] addr,
                                               input word_t wdata, input logic exp_hit);
        test_entry_t e;
        e.is_write = is_write;
        e.addr     = cache_addr_t'(addr);
        e.wdata    = wdata;
        e.exp_hit  = exp_hit;
        return e;
    endfunction

    // Memory wraps every MEM_WORDS words
    function automatic logic [IDX_W-1:0] mem_word_index(input cache_addr_t addr);
        return IDX_W'(int'(addr) % MEM_WORDS);
    endfunction

    task automatic build_table();
        // Cold miss, then a hit in the same line
        tests[0]  = make_entry(RD, 16'h0005, 16'h0000, MISS);
        tests[1]  = make_entry(RD, 16'h0007, 16'h0000, HIT);
        // Three tags in set 0, LRU replacement
        tests[2]  = make_entry(RD, 16'h0000, 16'h0000, MISS);
        tests[3]  = make_entry(RD, 16'h0009, 16'h0000, MISS);
        tests[4]  = make_entry(RD, 16'h0002, 16'h0000, HIT);
        tests[5]  = make_entry(RD, 16'h0012, 16'h0000, MISS);
        tests[6]  = make_entry(RD, 16'h0003, 16'h0000, HIT);
        tests[7]  = make_entry(RD, 16'h000A, 16'h0000, MISS);
        // Write hit, then evict the line and read it back from memory
        tests[8]  = make_entry(WR, 16'h0006, word_t'($random(seed)), HIT);
        tests[9]  = make_entry(RD, 16'h0006, 16'h0000, HIT);
        tests[10] = make_entry(RD, 16'h000C, 16'h0000, MISS);
        tests[11] = make_entry(RD, 16'h0014, 16'h0000, MISS);
        tests[12] = make_entry(RD, 16'h0004, 16'h0000, MISS);
        tests[13] = make_entry(RD, 16'h0006, 16'h0000, HIT);
        // Write miss does not allocate
        tests[14] = make_entry(WR, 16'h0020, word_t'($random(seed)), MISS);
        tests[15] = make_entry(RD, 16'h0020, 16'h0000, MISS);
        // Read miss right behind a write hit waits for the line write
        tests[16] = make_entry(WR, 16'h0021, word_t'($random(seed)), HIT);
        tests[17] = make_entry(RD, 16'h0018, 16'h0000, MISS);
        tests[18] = make_entry(RD, 16'h0021, 16'h0000, HIT);
        tests[19] = make_entry(RD, 16'h0008, 16'h0000, MISS);
        tests[20] = make_entry(RD, 16'h0010, 16'h0000, MISS);
        tests[21] = make_entry(RD, 16'h0021, 16'h0000, MISS);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp);
            error_count++;
        end
    endtask

    // Two cycles from accept to ready mean a hit and anything longer a miss
    task automatic check_hit(input string name, input int cycles, input logic exp_hit);
        logic got_hit;
        got_hit = (cycles == 2);
        if (got_hit !== exp_hit) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h (%0d cycles)",
                     name, got_hit, exp_hit, cycles);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // Waits for ready, issues one access and returns when ready comes back
    task automatic apply_access(input test_entry_t t, output int cycles,
                                output word_t rdata, output logic rd_done);
        cpu_req_t req;
        req.read  = !t.is_write;
        req.write = t.is_write;
        req.addr  = t.addr;
        req.wdata = t.wdata;
        @(negedge clk);
        while (!o_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        i_req <= req;
        // Accept edge
        @(posedge clk);
        i_req <= '0;
        cycles = 0;
        @(negedge clk);
        while (!o_ready) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        rdata   = o_rdata;
        rd_done = o_rd_done;
    endtask

    initial begin
        test_entry_t t;
        word_t       rdata;
        logic        rd_done;
        int          cycles;
        int          errors_before;
        clk         = 1'b0;
        reset_n     = 1'b0;
        i_req       = '0;
        seed        = 37593;
        cycle_count = 0;
        error_count = 0;
        pass_count  = 0;
        // Same start values as the memory model
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = ~word_t'(i);
        end
        build_table();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            t             = tests[i];
            errors_before = error_count;
            apply_access(t, cycles, rdata, rd_done);
            check_hit("hit", cycles, t.exp_hit);
            check_flag("o_rd_done", rd_done, !t.is_write);
            if (t.is_write) begin
                ref_mem[mem_word_index(t.addr)] = t.wdata;
            end else begin
                check_word("o_rdata", rdata, ref_mem[mem_word_index(t.addr)]);
            end
            if (error_count == errors_before) begin
                pass_count++;
            end
            $display("Test %0d: %s addr 0x%04h data 0x%04h, %0d cycles, %s", i,
                     t.is_write ? "WR" : "RD", t.addr, t.is_write ? t.wdata : rdata,
                     cycles, (error_count == errors_before) ? "ok" : "error");
        end

        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 pass_count, NUM_TESTS - pass_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  cpu_req_t    i_req,
    output logic        o_ready,
    output word_t       o_rdata,
    output logic        o_rd_done,
    input  logic        i_hit,
    input  word_t       i_rword,
    input  line_u       i_merged,
    output cache_addr_t o_addr,
    output word_t       o_wdata,
    output logic        o_lru_touch,
    output logic        o_fill,
    output line_u       o_fill_line,
    output logic        o_write_hit,
    output mem_req_t    o_mem_req,
    input  logic        i_mem_ack,
    input  line_u       i_mem_rdata
);

    typedef enum logic [2:0] {
        S_READY,
        S_LOOKUP,
        S_RESP,
        S_MEM_WAIT,
        S_MEM_READ,
        S_MEM_WWORD
    } state_t;

    state_t   state;
    cpu_req_t req_q;
    // Background line write from a write hit still in flight
    logic     wr_pending;
    logic     wr_busy;
    logic     need_mem;
    // Any memory request between strobe and ack
    logic     mem_busy;
    logic     accept;

    assign accept   = (state == S_READY) && (i_req.read || i_req.write);
    // An ack this cycle retires the background write
    assign wr_busy  = wr_pending && !i_mem_ack;
    assign need_mem = req_q.write || !i_hit;

    assign o_addr      = req_q.addr;
    assign o_wdata     = req_q.wdata;
    assign o_fill_line = i_mem_rdata;
    assign o_lru_touch = (state == S_LOOKUP) && req_q.read && i_hit;
    assign o_write_hit = (state == S_LOOKUP) && req_q.write && i_hit && !wr_busy;
    assign o_fill      = (state == S_MEM_READ) && i_mem_ack;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= S_READY;
            o_ready         <= 1'b1;
            o_rd_done       <= 1'b0;
            wr_pending      <= 1'b0;
            o_mem_req.read  <= 1'b0;
            o_mem_req.write <= 1'b0;
        end else begin
            o_rd_done       <= 1'b0;
            o_mem_req.read  <= 1'b0;
            o_mem_req.write <= 1'b0;

            if (o_write_hit) begin
                wr_pending <= 1'b1;
            end else if (i_mem_ack) begin
                wr_pending <= 1'b0;
            end

            case (state)
                S_READY: begin
                    if (accept) begin
                        o_ready <= 1'b0;
                        state   <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (need_mem && wr_busy) begin
                        state <= S_MEM_WAIT;
                    end else if (req_q.read && i_hit) begin
                        o_rdata <= i_rword;
                        state   <= S_RESP;
                    end else if (req_q.read) begin
                        // Fetch the aligned line
                        o_mem_req.read      <= 1'b1;
                        o_mem_req.line_size <= 1'b1;
                        o_mem_req.addr      <= '{tag: req_q.addr.tag,
                                                 index: req_q.addr.index,
                                                 offset: 2'b00};
                        state <= S_MEM_READ;
                    end else if (i_hit) begin
                        // Write-through of the merged line while the CPU moves on
                        o_mem_req.write     <= 1'b1;
                        o_mem_req.line_size <= 1'b1;
                        o_mem_req.addr      <= '{tag: req_q.addr.tag,
                                                 index: req_q.addr.index,
                                                 offset: 2'b00};
                        o_mem_req.wdata     <= i_merged;
                        state <= S_RESP;
                    end else begin
                        // No allocate on write miss
                        o_mem_req.write     <= 1'b1;
                        o_mem_req.line_size <= 1'b0;
                        o_mem_req.addr      <= req_q.addr;
                        o_mem_req.wdata.raw <= 64'(req_q.wdata);
                        state <= S_MEM_WWORD;
                    end
                end
                S_RESP: begin
                    o_ready   <= 1'b1;
                    o_rd_done <= req_q.read;
                    state     <= S_READY;
                end
                S_MEM_WAIT: begin
                    if (!wr_busy) begin
                        state <= S_LOOKUP;
                    end
                end
                S_MEM_READ: begin
                    if (i_mem_ack) begin
                        o_rdata   <= i_mem_rdata.words[req_q.addr.offset];
                        o_ready   <= 1'b1;
                        o_rd_done <= 1'b1;
                        state     <= S_READY;
                    end
                end
                S_MEM_WWORD: begin
                    if (i_mem_ack) begin
                        o_ready <= 1'b1;
                        state   <= S_READY;
                    end
                end
                default: state <= S_READY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_busy <= 1'b0;
        end else if (o_mem_req.read || o_mem_req.write) begin
            mem_busy <= 1'b1;
        end else if (i_mem_ack) begin
            mem_busy <= 1'b0;
        end
    end

    a_one_mem_req: assert property (
        @(posedge clk) disable iff (!reset_n)
        (o_mem_req.read || o_mem_req.write) |-> !mem_busy
    );

    a_mem_rw_excl: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(o_mem_req.read && o_mem_req.write)
    );

endmodule

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // Arrays in cache_store are built for exactly this many ways
    localparam int NUM_WAYS = 2;

    typedef logic [15:0] word_t;

    // Word address split into tag, set index and word offset
    typedef struct packed {
        logic [12:0] tag;
        logic        index;
        logic [1:0]  offset;
    } cache_addr_t;

    // One cache line, seen flat or as four words
    typedef union packed {
        logic [63:0]     raw;
        word_t [3:0]     words;
    } line_u;

    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_t addr;
        word_t       wdata;
    } cpu_req_t;

    // line_size 1 = whole line, 0 = single word in wdata.words[0]
    typedef struct packed {
        logic        read;
        logic        write;
        logic        line_size;
        cache_addr_t addr;
        line_u       wdata;
    } mem_req_t;

endpackage

// ==== verilog/cache_store.sv ====
`timescale 1ns/1ps

module cache_store
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  cache_addr_t i_addr,
    input  logic        i_lru_touch,
    input  logic        i_fill,
    input  line_u       i_fill_line,
    input  logic        i_write_hit,
    input  word_t       i_wdata,
    output logic        o_hit,
    output logic        o_hit_way,
    output word_t       o_rword,
    output line_u       o_merged
);

    // Indexed [set][way]
    logic [NUM_WAYS-1:0] valid [2];
    // Indexed [way][set]
    logic [12:0]         tag_mem [NUM_WAYS][2];
    line_u               data_mem [NUM_WAYS][2];
    // Way to replace next, per set
    logic                lru [2];

    logic [NUM_WAYS-1:0] way_hit;
    logic                fill_way;
    line_u               hit_line;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid[i_addr.index][w] &&
                         (tag_mem[w][i_addr.index] == i_addr.tag);
        end
    end

    assign o_hit     = |way_hit;
    assign o_hit_way = way_hit[1];
    assign hit_line  = data_mem[o_hit_way][i_addr.index];
    assign o_rword   = hit_line.words[i_addr.offset];

    // Hit line with the new word dropped in at its offset
    always_comb begin
        o_merged = hit_line;
        o_merged.words[i_addr.offset] = i_wdata;
    end

    // Invalid way first, otherwise the LRU way
    assign fill_way = !valid[i_addr.index][0] ? 1'b0 :
                      !valid[i_addr.index][1] ? 1'b1 :
                      lru[i_addr.index];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '{default: '0};
            lru   <= '{default: 1'b0};
        end else if (i_fill) begin
            valid[i_addr.index][fill_way] <= 1'b1;
            lru[i_addr.index] <= ~fill_way;
        end else if (i_lru_touch || i_write_hit) begin
            lru[i_addr.index] <= ~o_hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[fill_way][i_addr.index]  <= i_addr.tag;
            data_mem[fill_way][i_addr.index] <= i_fill_line;
        end else if (i_write_hit) begin
            data_mem[o_hit_way][i_addr.index] <= o_merged;
        end
    end

    // Fill only happens on a miss, so a tag lives in one way at most
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(way_hit[0] && way_hit[1])
    );

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
#(
    parameter int MEM_LINES   = 16,
    parameter int MEM_LATENCY = 4
) (
    input  logic     clk,
    input  logic     reset_n,
    input  cpu_req_t i_req,
    output logic     o_ready,
    output word_t    o_rdata,
    output logic     o_rd_done
);

    cache_addr_t lookup_addr;
    word_t       lookup_wdata;
    logic        lru_touch;
    logic        fill;
    line_u       fill_line;
    logic        write_hit;
    logic        hit;
    word_t       rword;
    line_u       merged;
    mem_req_t    mem_req;
    logic        mem_ack;
    line_u       mem_rdata;

    cache_ctrl cache_ctrl_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_req       (i_req),
        .o_ready     (o_ready),
        .o_rdata     (o_rdata),
        .o_rd_done   (o_rd_done),
        .i_hit       (hit),
        .i_rword     (rword),
        .i_merged    (merged),
        .o_addr      (lookup_addr),
        .o_wdata     (lookup_wdata),
        .o_lru_touch (lru_touch),
        .o_fill      (fill),
        .o_fill_line (fill_line),
        .o_write_hit (write_hit),
        .o_mem_req   (mem_req),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata)
    );

    // Hit way is only needed inside the store
    cache_store cache_store_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_addr      (lookup_addr),
        .i_lru_touch (lru_touch),
        .i_fill      (fill),
        .i_fill_line (fill_line),
        .i_write_hit (write_hit),
        .i_wdata     (lookup_wdata),
        .o_hit       (hit),
        .o_hit_way   (),
        .o_rword     (rword),
        .o_merged    (merged)
    );

    line_memory #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) line_memory_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_mem_req (mem_req),
        .o_ack     (mem_ack),
        .o_rdata   (mem_rdata)
    );

endmodule

// ==== verilog/line_memory.sv ====
`timescale 1ns/1ps

// MEM_LATENCY must be at least 2
module line_memory
    import cache_pkg::*;
#(
    parameter int MEM_LINES   = 16,
    parameter int MEM_LATENCY = 4
) (
    input  logic     clk,
    input  logic     reset_n,
    input  mem_req_t i_mem_req,
    output logic     o_ack,
    output line_u    o_rdata
);

    localparam int LINE_W = $clog2(MEM_LINES);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

    line_u             mem [MEM_LINES];
    mem_req_t          req_q;
    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic [LINE_W-1:0] line_sel;

    // Line number is the word address over four, wrapped to the array
    assign line_sel = LINE_W'({req_q.addr.tag, req_q.addr.index} % MEM_LINES);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            o_ack <= 1'b0;
            // Each word starts as the inverse of its own address
            for (int l = 0; l < MEM_LINES; l++) begin
                for (int w = 0; w < 4; w++) begin
                    mem[l].words[w] <= ~word_t'(l * 4 + w);
                end
            end
        end else begin
            o_ack <= 1'b0;
            if (!busy) begin
                if (i_mem_req.read || i_mem_req.write) begin
                    req_q <= i_mem_req;
                    busy  <= 1'b1;
                    cnt   <= CNT_W'(MEM_LATENCY - 1);
                end
            end else if (cnt == CNT_W'(1)) begin
                o_ack <= 1'b1;
                busy  <= 1'b0;
                if (req_q.read) begin
                    o_rdata <= mem[line_sel];
                end else if (req_q.line_size) begin
                    mem[line_sel] <= req_q.wdata;
                end else begin
                    mem[line_sel].words[req_q.addr.offset] <= req_q.wdata.words[0];
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    a_no_strobe_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        busy |-> !(i_mem_req.read || i_mem_req.write)
    );

endmodule
